// ==== hazardPkg.sv ====
`default_nettype none

package hazardPkg;

    typedef logic [4:0] regNum_t;
    typedef logic [1:0] stageTime_t;

    typedef struct packed {
        regNum_t    rsNum;
        regNum_t    rtNum;
        stageTime_t tuseRs;
        stageTime_t tuseRt;
    } useInfo_t;

    typedef struct packed {
        regNum_t    regNum;
        stageTime_t tnew;
    } newInfo_t;

    localparam regNum_t regZero = 5'd0;
    localparam regNum_t linkReg = 5'd31;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////
    localparam logic [5:0] opR    = 6'h00;
    localparam logic [5:0] opJ    = 6'h02;
    localparam logic [5:0] opJal  = 6'h03;
    localparam logic [5:0] opBeq  = 6'h04;
    localparam logic [5:0] opBne  = 6'h05;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri  = 6'h0d;
    localparam logic [5:0] opLui  = 6'h0f;
    localparam logic [5:0] opLb   = 6'h20;
    localparam logic [5:0] opLh   = 6'h21;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSb   = 6'h28;
    localparam logic [5:0] opSh   = 6'h29;
    localparam logic [5:0] opSw   = 6'h2b;
    localparam logic [5:0] opLwmx = 6'h33;

    //////////////////////////////////////////////////
    // Function codes of the R-type opcode
    //////////////////////////////////////////////////
    localparam logic [5:0] fnJr    = 6'h08;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMthi  = 6'h11;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMtlo  = 6'h13;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnDiv   = 6'h1a;
    localparam logic [5:0] fnDivu  = 6'h1b;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnSltu  = 6'h2b;

    function automatic logic isAluR(logic [5:0] funct);
        return funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu};
    endfunction

    // Destination register as seen from Execute
    function automatic regNum_t destOf(logic [31:0] instr);
        regNum_t dest;
        dest = regZero;
        case (instr[31:26])
            opR: begin
                if (isAluR(instr[5:0]) || instr[5:0] == fnMfhi || instr[5:0] == fnMflo) begin
                    dest = instr[15:11];
                end
            end
            opOri, opAddi, opAndi, opLui, opLw, opLb, opLh, opLwmx: dest = instr[20:16];
            opJal: dest = linkReg;
            default: dest = regZero;
        endcase
        return dest;
    endfunction

endpackage

`default_nettype wire

// ==== hazardUnit.f ====
hazardPkg.sv
useDecoder.sv
newDecoder.sv
newTracker.sv
stallControl.sv
hazardUnit.sv
hazardUnitTb.sv

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [31:0]         instrD,
    input  wire logic [31:0]         instrE,
    input  wire logic [31:0]         instrM,
    input  wire logic                condition,
    input  wire logic                regWriteE,
    input  wire logic                regWriteM,
    input  wire logic                busy,
    input  wire logic                start,
    output logic                     pcWrite,
    output logic                     ifIdEn,
    output logic                     idExClr,
    output logic                     mduClr,
    output hazardPkg::useInfo_t      useD,
    output hazardPkg::newInfo_t      newE,
    output hazardPkg::newInfo_t      newM
);

    useDecoder useDecoder_inst (
        .instrD (instrD),
        .useD   (useD)
    );

    newDecoder newDecoder_inst (
        .instrE (instrE),
        .newE   (newE)
    );

    newTracker newTracker_inst (
        .clk       (clk),
        .reset     (reset),
        .newE      (newE),
        .instrM    (instrM),
        .condition (condition),
        .newM      (newM)
    );

    stallControl stallControl_inst (
        .useD      (useD),
        .newE      (newE),
        .newM      (newM),
        .instrD    (instrD),
        .instrE    (instrE),
        .regWriteE (regWriteE),
        .regWriteM (regWriteM),
        .busy      (busy),
        .start     (start),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr),
        .mduClr    (mduClr)
    );

endmodule

`default_nettype wire

// ==== hazardUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnitTb;

    localparam int resetCycles    = 2;
    localparam int directedCycles = 20;
    localparam int randomCycles   = 150;
    localparam int cycleLimit     = 2 * (resetCycles + directedCycles + randomCycles);

    localparam logic [5:0] fnTable [15] = '{
        hazardPkg::fnAdd, hazardPkg::fnSub, hazardPkg::fnAnd, hazardPkg::fnOr,
        hazardPkg::fnSlt, hazardPkg::fnSltu, hazardPkg::fnMult, hazardPkg::fnMultu,
        hazardPkg::fnDiv, hazardPkg::fnDivu, hazardPkg::fnMfhi, hazardPkg::fnMflo,
        hazardPkg::fnMthi, hazardPkg::fnMtlo, hazardPkg::fnJr
    };
    localparam logic [5:0] opTable [15] = '{
        hazardPkg::opOri, hazardPkg::opAddi, hazardPkg::opAndi, hazardPkg::opLui,
        hazardPkg::opLw, hazardPkg::opLb, hazardPkg::opLh, hazardPkg::opLwmx,
        hazardPkg::opSw, hazardPkg::opSb, hazardPkg::opSh, hazardPkg::opBeq,
        hazardPkg::opBne, hazardPkg::opJ, hazardPkg::opJal
    };

    logic clk;
    logic reset;
    logic [31:0] instrD, instrE, instrM;
    logic condition, regWriteE, regWriteM, busy, start;
    logic pcWrite, ifIdEn, idExClr, mduClr;
    hazardPkg::useInfo_t useD;
    hazardPkg::newInfo_t newE;
    hazardPkg::newInfo_t newM;

    string testName = "reset";
    integer seed;
    int errors = 0;
    int cycles = 0;

    // Model state
    logic stallExp;
    logic mduClrExp;
    logic mduBusy;
    logic rTypeD;
    logic [1:0] tnewMModel;
    hazardPkg::useInfo_t useExp;
    hazardPkg::newInfo_t newEExp;
    hazardPkg::newInfo_t newMExp;

    hazardUnit hazardUnit_inst (
        .clk(clk), .reset(reset), .instrD(instrD), .instrE(instrE), .instrM(instrM),
        .condition(condition), .regWriteE(regWriteE), .regWriteM(regWriteM),
        .busy(busy), .start(start), .pcWrite(pcWrite), .ifIdEn(ifIdEn),
        .idExClr(idExClr), .mduClr(mduClr), .useD(useD), .newE(newE), .newM(newM)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Instruction builders
    //////////////////////////////////////////////////
    function automatic logic [31:0] rType(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt);
        return {op, rs, rt, 16'h0010};
    endfunction

    function automatic logic [31:0] randomInstr();
        int sel;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        sel = int'($unsigned($random(seed)) % 30);
        rs = 5'($unsigned($random(seed)) % 4);
        rt = 5'($unsigned($random(seed)) % 4);
        rd = 5'($unsigned($random(seed)) % 4);
        if (sel < 15)
            return rType(fnTable[sel], rs, rt, rd);
        return iType(opTable[sel - 15], rs, rt);
    endfunction

    //////////////////////////////////////////////////
    // Timing model
    //////////////////////////////////////////////////
    function automatic hazardPkg::useInfo_t useOf(logic [31:0] instr);
        logic [5:0] fn;
        hazardPkg::useInfo_t u;
        fn = instr[5:0];
        u = '0;
        case (instr[31:26])
            hazardPkg::opR:
                if (fn inside {[6'h20:6'h2b]} && !(fn inside {6'h21, 6'h23, 6'h26, 6'h27,
                                                              6'h28, 6'h29}))
                    u = {instr[25:21], instr[20:16], 2'd1, 2'd1};
                else if (fn inside {[6'h18:6'h1b]})
                    u = {instr[25:21], instr[20:16], 2'd1, 2'd1};
                else if (fn == 6'h11 || fn == 6'h13)
                    u = {instr[25:21], 5'd0, 2'd1, 2'd0};
                else if (fn == 6'h08)
                    u = {instr[25:21], 5'd0, 2'd0, 2'd0};
            6'h0d, 6'h08, 6'h0c, 6'h23, 6'h20, 6'h21:
                u = {instr[25:21], 5'd0, 2'd1, 2'd0};
            6'h2b, 6'h28, 6'h29, 6'h33:
                u = {instr[25:21], instr[20:16], 2'd1, 2'd2};
            6'h04, 6'h05:
                u = {instr[25:21], instr[20:16], 2'd0, 2'd0};
            default:
                u = '0;
        endcase
        return u;
    endfunction

    function automatic hazardPkg::newInfo_t productionOf(logic [31:0] instr);
        logic [5:0] fn;
        hazardPkg::newInfo_t p;
        fn = instr[5:0];
        p = '0;
        case (instr[31:26])
            hazardPkg::opR:
                if (fn inside {6'h20, 6'h22, 6'h24, 6'h25, 6'h2a, 6'h2b, 6'h10, 6'h12})
                    p = {instr[15:11], 2'd1};
            6'h0d, 6'h08, 6'h0c, 6'h0f: p = {instr[20:16], 2'd1};
            6'h23, 6'h20, 6'h21, 6'h33: p = {instr[20:16], 2'd2};
            6'h03: p = {5'd31, 2'd0};
            default: p = '0;
        endcase
        return p;
    endfunction

    function automatic logic [4:0] memoryDest(logic [31:0] instr, logic cond);
        if (instr[31:26] == 6'h33)
            return cond ? instr[20:16] : 5'd31;
        return productionOf(instr).regNum;
    endfunction

    function automatic logic tooEarly(logic [4:0] num, logic [1:0] tuse,
                                      hazardPkg::newInfo_t prod, logic we);
        return num != 5'd0 && num == prod.regNum && we && tuse < prod.tnew;
    endfunction

    always_comb begin
        useExp = useOf(instrD);
        newEExp = productionOf(instrE);
        newMExp = {memoryDest(instrM, condition), tnewMModel};
        mduBusy = busy || start;
        rTypeD = instrD[31:26] == 6'h00;
        stallExp = tooEarly(useExp.rsNum, useExp.tuseRs, newEExp, regWriteE) ||
                   tooEarly(useExp.rsNum, useExp.tuseRs, newMExp, regWriteM) ||
                   tooEarly(useExp.rtNum, useExp.tuseRt, newEExp, regWriteE) ||
                   tooEarly(useExp.rtNum, useExp.tuseRt, newMExp, regWriteM) ||
                   (mduBusy && rTypeD && instrD[5:0] inside {[6'h10:6'h13]}) ||
                   instrE[31:26] == 6'h33;
        mduClrExp = mduBusy && rTypeD && instrD[5:0] inside {[6'h18:6'h1b]};
    end

    always @(posedge clk) begin
        if (reset)
            tnewMModel <= 2'd0;
        else
            tnewMModel <= (newEExp.tnew == 2'd0) ? 2'd0 : newEExp.tnew - 2'd1;
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED %s %s: expected %h actual %h", testName, what, expected, actual);
    endtask

    controlsMatch: assert property (@(posedge clk) disable iff (reset)
        {pcWrite, ifIdEn, idExClr, mduClr} == {!stallExp, !stallExp, stallExp, mduClrExp})
        else reportMismatch("controls",
                            32'($sampled({!stallExp, !stallExp, stallExp, mduClrExp})),
                            32'($sampled({pcWrite, ifIdEn, idExClr, mduClr})));
    useMatch: assert property (@(posedge clk) disable iff (reset) useD == useExp)
        else reportMismatch("useD", 32'($sampled(useExp)), 32'($sampled(useD)));
    newEMatch: assert property (@(posedge clk) disable iff (reset) newE == newEExp)
        else reportMismatch("newE", 32'($sampled(newEExp)), 32'($sampled(newE)));
    newMMatch: assert property (@(posedge clk) disable iff (reset) newM == newMExp)
        else reportMismatch("newM", 32'($sampled(newMExp)), 32'($sampled(newM)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: no end of test after %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    // ctl is {regWriteE, regWriteM, busy, start, condition}
    task automatic applyCycle(input string name, input logic [31:0] d, input logic [31:0] e,
                              input logic [31:0] m, input logic [4:0] ctl);
        testName = name;
        instrD = d;
        instrE = e;
        instrM = m;
        {regWriteE, regWriteM, busy, start, condition} = ctl;
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed = 32'h626d;
        reset = 1'b1;
        // A load in Execute during reset must not leak into newM
        instrD = 32'd0;
        instrE = iType(hazardPkg::opLw, 5'd1, 5'd2);
        instrM = 32'd0;
        {regWriteE, regWriteM, busy, start, condition} = 5'b10000;
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;

        applyCycle("afterReset", 32'd0, 32'd0, 32'd0, 5'b01000);
        applyCycle("loadUse", rType(hazardPkg::fnAdd, 5'd2, 5'd1, 5'd3),
                   iType(hazardPkg::opLw, 5'd0, 5'd2), 32'd0, 5'b10000);
        applyCycle("aluNoStall", rType(hazardPkg::fnAdd, 5'd2, 5'd1, 5'd3),
                   iType(hazardPkg::opAddi, 5'd0, 5'd2), 32'd0, 5'b10000);
        applyCycle("storeData", iType(hazardPkg::opSw, 5'd1, 5'd2),
                   iType(hazardPkg::opLw, 5'd0, 5'd2), 32'd0, 5'b10000);
        applyCycle("branchAlu", iType(hazardPkg::opBeq, 5'd2, 5'd1),
                   iType(hazardPkg::opAddi, 5'd0, 5'd2), 32'd0, 5'b10000);
        applyCycle("regZero", rType(hazardPkg::fnAdd, 5'd0, 5'd0, 5'd3),
                   iType(hazardPkg::opLw, 5'd1, 5'd0), 32'd0, 5'b10000);
        applyCycle("writeOff", rType(hazardPkg::fnAdd, 5'd2, 5'd1, 5'd3),
                   iType(hazardPkg::opLw, 5'd0, 5'd2), 32'd0, 5'b00000);
        applyCycle("memLoad", 32'd0, iType(hazardPkg::opLw, 5'd1, 5'd2), 32'd0, 5'b10000);
        applyCycle("memBranch", iType(hazardPkg::opBeq, 5'd2, 5'd0), 32'd0,
                   iType(hazardPkg::opLw, 5'd1, 5'd2), 5'b01000);
        applyCycle("memLoad", 32'd0, iType(hazardPkg::opLw, 5'd1, 5'd2), 32'd0, 5'b10000);
        applyCycle("memAdd", rType(hazardPkg::fnAdd, 5'd2, 5'd0, 5'd3), 32'd0,
                   iType(hazardPkg::opLw, 5'd1, 5'd2), 5'b01000);
        applyCycle("mduBusy", rType(hazardPkg::fnMfhi, 5'd0, 5'd0, 5'd4), 32'd0, 32'd0, 5'b00100);
        applyCycle("mduStart", rType(hazardPkg::fnMtlo, 5'd1, 5'd0, 5'd0), 32'd0, 32'd0, 5'b00010);
        applyCycle("mduClr", rType(hazardPkg::fnMult, 5'd1, 5'd2, 5'd0), 32'd0, 32'd0, 5'b00100);
        applyCycle("lwmxExec", 32'd0, iType(hazardPkg::opLwmx, 5'd1, 5'd2), 32'd0, 5'b10000);
        applyCycle("lwmxHigh", iType(hazardPkg::opBeq, 5'd2, 5'd0), 32'd0,
                   iType(hazardPkg::opLwmx, 5'd1, 5'd2), 5'b01001);
        applyCycle("lwmxExec", 32'd0, iType(hazardPkg::opLwmx, 5'd1, 5'd2), 32'd0, 5'b10000);
        applyCycle("lwmxLow", rType(hazardPkg::fnJr, 5'd31, 5'd0, 5'd0), 32'd0,
                   iType(hazardPkg::opLwmx, 5'd1, 5'd2), 5'b01000);
        applyCycle("jalLink", rType(hazardPkg::fnJr, 5'd31, 5'd0, 5'd0),
                   iType(hazardPkg::opJal, 5'd0, 5'd0), 32'd0, 5'b10000);

        for (int i = 0; i < randomCycles; i++) begin
            applyCycle("random", randomInstr(), randomInstr(), randomInstr(),
                       5'($random(seed)));
        end

        @(posedge clk);
        #1;
        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== newDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module newDecoder (
    input  wire logic [31:0]         instrE,
    output hazardPkg::newInfo_t      newE
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    hazardPkg::stageTime_t tnew;

    assign opcode = instrE[31:26];
    assign funct  = instrE[5:0];

    // Cycles until the result leaves its producing stage
    always_comb begin
        tnew = 2'd0;
        case (opcode)
            hazardPkg::opR: begin
                if (hazardPkg::isAluR(funct) ||
                    funct == hazardPkg::fnMfhi || funct == hazardPkg::fnMflo) begin
                    tnew = 2'd1;
                end
            end
            hazardPkg::opOri, hazardPkg::opAddi, hazardPkg::opAndi, hazardPkg::opLui: begin
                tnew = 2'd1;
            end
            hazardPkg::opLw, hazardPkg::opLb, hazardPkg::opLh, hazardPkg::opLwmx: begin
                // Load data only exists after Memory
                tnew = 2'd2;
            end
            hazardPkg::opJal: begin
                // Link address is ready in Execute
                tnew = 2'd0;
            end
            default: begin
                tnew = 2'd0;
            end
        endcase
    end

    always_comb begin
        newE.regNum = hazardPkg::destOf(instrE);
        newE.tnew   = tnew;
    end

endmodule

`default_nettype wire

// ==== newTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module newTracker (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire hazardPkg::newInfo_t newE,
    input  wire logic [31:0]         instrM,
    input  wire logic                condition,
    output hazardPkg::newInfo_t      newM
);

    hazardPkg::stageTime_t tnewM;

    // One stage later means one cycle less to wait
    always_ff @(posedge clk) begin
        if (reset) begin
            tnewM <= 2'd0;
        end else if (newE.tnew != 2'd0) begin
            tnewM <= newE.tnew - 2'd1;
        end else begin
            tnewM <= 2'd0;
        end
    end

    always_comb begin
        newM.tnew = tnewM;
        if (instrM[31:26] == hazardPkg::opLwmx) begin
            // Target chosen by the loaded word
            newM.regNum = condition ? instrM[20:16] : hazardPkg::linkReg;
        end else begin
            newM.regNum = hazardPkg::destOf(instrM);
        end
    end

    // Only loads reach Memory with time left, and they need just one more cycle
    tnewNeverTwo: assert property (
        @(posedge clk) disable iff (reset) tnewM != 2'd2
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f hazardUnit.f \
    --top-module hazardUnitTb -o hazardUnitSim > sim.log 2>&1 \
    && ./obj_dir/hazardUnitSim >> sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
if grep -q "Simulation failed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
echo "PASS"

// ==== stallControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stallControl (
    input  wire hazardPkg::useInfo_t useD,
    input  wire hazardPkg::newInfo_t newE,
    input  wire hazardPkg::newInfo_t newM,
    input  wire logic [31:0]         instrD,
    input  wire logic [31:0]         instrE,
    input  wire logic                regWriteE,
    input  wire logic                regWriteM,
    input  wire logic                busy,
    input  wire logic                start,
    output logic                     pcWrite,
    output logic                     ifIdEn,
    output logic                     idExClr,
    output logic                     mduClr
);

    logic dataStall;
    logic mduStall;
    logic lwmxStall;
    logic stall;
    logic mduActive;
    logic isRD;

    // Operand needed before the producer can forward it
    function automatic logic clash(hazardPkg::regNum_t useNum, hazardPkg::stageTime_t tuse,
                                   hazardPkg::newInfo_t prod, logic regWrite);
        return (useNum != hazardPkg::regZero) && (useNum == prod.regNum) &&
               regWrite && (tuse < prod.tnew);
    endfunction

    //////////////////////////////////////////////////
    // Stall sources
    //////////////////////////////////////////////////
    assign dataStall = clash(useD.rsNum, useD.tuseRs, newE, regWriteE) ||
                       clash(useD.rsNum, useD.tuseRs, newM, regWriteM) ||
                       clash(useD.rtNum, useD.tuseRt, newE, regWriteE) ||
                       clash(useD.rtNum, useD.tuseRt, newM, regWriteM);

    assign mduActive = busy || start;
    assign isRD      = instrD[31:26] == hazardPkg::opR;

    assign mduStall = mduActive && isRD &&
                      (instrD[5:0] inside {hazardPkg::fnMfhi, hazardPkg::fnMflo,
                                           hazardPkg::fnMthi, hazardPkg::fnMtlo});

    // Destination of lwmx stays unknown until Memory
    assign lwmxStall = instrE[31:26] == hazardPkg::opLwmx;

    assign stall = dataStall || mduStall || lwmxStall;

    //////////////////////////////////////////////////
    // Pipeline controls
    //////////////////////////////////////////////////
    assign pcWrite = ~stall;
    assign ifIdEn  = ~stall;
    assign idExClr = stall;

    // A new mult or div while the unit is occupied is dropped, not held
    assign mduClr = mduActive && isRD &&
                    (instrD[5:0] inside {hazardPkg::fnMult, hazardPkg::fnMultu,
                                         hazardPkg::fnDiv, hazardPkg::fnDivu});

endmodule

`default_nettype wire

// ==== useDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module useDecoder (
    input  wire logic [31:0]         instrD,
    output hazardPkg::useInfo_t      useD
);

    hazardPkg::regNum_t rs;
    hazardPkg::regNum_t rt;
    logic [5:0]         opcode;
    logic [5:0]         funct;

    assign rs     = instrD[25:21];
    assign rt     = instrD[20:16];
    assign opcode = instrD[31:26];
    assign funct  = instrD[5:0];

    always_comb begin
        useD.rsNum  = hazardPkg::regZero;
        useD.rtNum  = hazardPkg::regZero;
        useD.tuseRs = 2'd0;
        useD.tuseRt = 2'd0;
        case (opcode)
            hazardPkg::opR: begin
                if (hazardPkg::isAluR(funct) ||
                    funct inside {hazardPkg::fnMult, hazardPkg::fnMultu,
                                  hazardPkg::fnDiv, hazardPkg::fnDivu}) begin
                    useD.rsNum  = rs;
                    useD.rtNum  = rt;
                    useD.tuseRs = 2'd1;
                    useD.tuseRt = 2'd1;
                end else if (funct == hazardPkg::fnMthi || funct == hazardPkg::fnMtlo) begin
                    useD.rsNum  = rs;
                    useD.tuseRs = 2'd1;
                end else if (funct == hazardPkg::fnJr) begin
                    // Jump target needed in Decode
                    useD.rsNum  = rs;
                end
                // mfhi and mflo read no general register
            end
            hazardPkg::opOri, hazardPkg::opAddi, hazardPkg::opAndi,
            hazardPkg::opLw, hazardPkg::opLb, hazardPkg::opLh: begin
                useD.rsNum  = rs;
                useD.tuseRs = 2'd1;
            end
            hazardPkg::opSw, hazardPkg::opSb, hazardPkg::opSh, hazardPkg::opLwmx: begin
                // Store data is only needed in Memory
                useD.rsNum  = rs;
                useD.rtNum  = rt;
                useD.tuseRs = 2'd1;
                useD.tuseRt = 2'd2;
            end
            hazardPkg::opBeq, hazardPkg::opBne: begin
                useD.rsNum = rs;
                useD.rtNum = rt;
            end
            hazardPkg::opLui, hazardPkg::opJ, hazardPkg::opJal: begin
                useD.rsNum = hazardPkg::regZero;
            end
            default: begin
                useD.rsNum = hazardPkg::regZero;
            end
        endcase
    end

endmodule

`default_nettype wire
